/* source/op_consts.svh */
// ------------------------------------------------------------
// Output stage constants
// Port count, bus widths and longest fixed burst
// ------------------------------------------------------------
`ifndef OP_CONSTS_SVH
`define OP_CONSTS_SVH

`define OP_NUM_PORTS 3    // Bus-switch inputs sharing the slave
`define OP_ADDR_W    32   // HADDR width
`define OP_DATA_W    32   // HWDATA width
`define OP_MAX_BEATS 16   // INCR16/WRAP16 length

`endif

/* source/ahb_pkg.sv */
// ------------------------------------------------------------
// AHB protocol types
// Transfer, burst and sideband field encodings
// ------------------------------------------------------------
`include "op_consts.svh"

package ahb_pkg;

  // HTRANS encodings
  typedef enum logic [1:0] {
    IDLE   = 2'b00,                            // No transfer
    BUSY   = 2'b01,                            // Burst pause
    NONSEQ = 2'b10,                            // First beat
    SEQ    = 2'b11                             // Follow-on beat
  } htrans_t;

  // HBURST encodings
  typedef enum logic [2:0] {
    SINGLE = 3'b000,                           // Single beat
    INCR   = 3'b001,                           // Undefined length
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } hburst_t;

  typedef logic [2:0] hsize_t;                 // Bytes per beat, log2
  typedef logic [3:0] hprot_t;                 // Protection control
  typedef logic [3:0] hmaster_t;               // Master ID

  typedef logic [`OP_ADDR_W-1:0] addr_t;       // Address bus
  typedef logic [`OP_DATA_W-1:0] data_t;       // Write data bus

endpackage

/* source/matrix_pkg.sv */
// ------------------------------------------------------------
// Bus-matrix internal types
// Port index, arbiter state and address-phase payload
// ------------------------------------------------------------
`include "op_consts.svh"

package matrix_pkg;
  import ahb_pkg::*;

  typedef logic [$clog2(`OP_NUM_PORTS)-1:0]   port_idx_t;  // Input port 0..2
  typedef logic [$clog2(`OP_MAX_BEATS+1)-1:0] beat_cnt_t;  // Beats 0..16

  // Grant ownership
  typedef enum logic [1:0] {
    ARB_IDLE   = 2'b00,                        // Nobody owns the slave
    ARB_OWNED  = 2'b01,                        // Normal ownership
    ARB_LOCKED = 2'b10                         // Locked sequence
  } arb_state_t;

  // Address-phase fields routed as one payload
  typedef struct packed {
    logic     hsel;
    addr_t    haddr;
    htrans_t  htrans;
    logic     hwrite;
    hsize_t   hsize;
    hburst_t  hburst;
    hprot_t   hprot;
    hmaster_t hmaster;
    logic     hmastlock;
  } addr_ctrl_t;

endpackage

/* source/op_arbiter.sv */
// ------------------------------------------------------------
// Output stage arbiter
// Fixed priority grant, port 0 highest, held through fixed
// bursts, SEQ/BUSY beats and locked sequences
// ------------------------------------------------------------
`include "op_consts.svh"

module op_arbiter (
  input  logic                     HCLK,
  input  logic                     HRESETn,
  input  logic [`OP_NUM_PORTS-1:0] i_req,         // Per-port request
  input  logic                     i_hready,      // HREADYMUX from data phase
  input  logic                     i_hsel,        // Owner's HSEL
  input  ahb_pkg::htrans_t         i_htrans,      // Owner's HTRANS
  input  logic                     i_hmastlock,   // Owner's HMASTLOCK
  input  logic                     i_burst_busy,  // Fixed burst beats left
  output matrix_pkg::port_idx_t    o_grant,
  output logic                     o_no_port
);
  import ahb_pkg::*;
  import matrix_pkg::*;

  arb_state_t state;
  arb_state_t state_nxt;
  port_idx_t  grant_nxt;
  port_idx_t  pick;        // Highest priority requester
  logic       hsel_lock;   // Lock seen while selected
  logic       hsel_lock_nxt;
  logic       lock_arb;    // Lock as seen by arbitration
  logic       mid_burst;   // Owner inside a burst
  logic       hold;        // Keep the current owner

  // ----------------------------------------------------------
  // Lock tracking
  // ----------------------------------------------------------
  // A locked master may address another slave mid-sequence,
  // so the lock is remembered once it started on this slave
  assign hsel_lock_nxt = (i_hsel & i_hmastlock & ((i_htrans == NONSEQ) | (i_htrans == SEQ))) ?
                         1'b1 :
                         (i_hmastlock ? hsel_lock : 1'b0);

  assign lock_arb  = i_hmastlock & (hsel_lock | i_hsel);   // Mask lock when not ours
  assign mid_burst = (i_htrans == SEQ) | (i_htrans == BUSY);
  assign hold      = (state != ARB_IDLE) & (i_burst_busy | lock_arb | mid_burst);

  // ----------------------------------------------------------
  // Priority pick and next state
  // ----------------------------------------------------------
  always_comb
  begin
    pick = '0;
    for (int p = `OP_NUM_PORTS-1; p >= 0; p--)
    begin
      if (i_req[p])
        pick = port_idx_t'(p);                // Lower index overrides
    end
  end

  always_comb
  begin
    grant_nxt = o_grant;                      // Default keep grant
    if (hold)
      state_nxt = lock_arb ? ARB_LOCKED : ARB_OWNED;
    else if (|i_req)
    begin
      grant_nxt = pick;
      state_nxt = ARB_OWNED;
    end
    else
      state_nxt = ARB_IDLE;                   // Nobody wants the slave
  end

  // Everything advances only on accepted edges
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      state     <= ARB_IDLE;
      o_grant   <= '0;
      hsel_lock <= 1'b0;
    end
    else if (i_hready)
    begin
      state     <= state_nxt;
      o_grant   <= grant_nxt;
      hsel_lock <= hsel_lock_nxt;
    end
  end

  assign o_no_port = (state == ARB_IDLE);

  // Grant must name a real input port once owned
  a_grant_range: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !o_no_port |-> (o_grant < `OP_NUM_PORTS));

  // Stalled slave freezes ownership
  a_grant_stall: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !i_hready |=> $stable(o_grant));

endmodule

/* source/op_beat_counter.sv */
// ------------------------------------------------------------
// Fixed-length burst beat counter
// Tracks beats left on the output port for grant holding
// ------------------------------------------------------------
`include "op_consts.svh"

module op_beat_counter (
  input  logic             HCLK,
  input  logic             HRESETn,
  input  logic             i_hready,      // Accepted edge
  input  ahb_pkg::htrans_t i_htrans,      // Muxed HTRANS
  input  ahb_pkg::hburst_t i_hburst,      // Muxed HBURST
  input  logic             i_hsel,        // Muxed HSEL
  output logic             o_burst_busy   // Beats still to come
);
  import ahb_pkg::*;
  import matrix_pkg::*;

  beat_cnt_t beats_left;   // Remaining SEQ beats
  beat_cnt_t burst_len;    // Decoded burst length
  logic      fixed_burst;
  logic      first_beat;   // NONSEQ opening a fixed burst
  logic      next_beat;    // SEQ inside a fixed burst

  // Burst length decode
  always_comb
  begin
    case (i_hburst)
      WRAP4, INCR4:   burst_len = beat_cnt_t'(4);
      WRAP8, INCR8:   burst_len = beat_cnt_t'(8);
      WRAP16, INCR16: burst_len = beat_cnt_t'(`OP_MAX_BEATS);
      SINGLE, INCR:   burst_len = '0;          // Nothing to hold for
    endcase
  end

  assign fixed_burst = (burst_len != '0);
  assign first_beat  = i_hsel & (i_htrans == NONSEQ) & fixed_burst;
  assign next_beat   = i_hsel & (i_htrans == SEQ) & fixed_burst;

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      beats_left <= '0;
    else if (i_hready)
    begin
      if (first_beat)
        beats_left <= burst_len - 1'b1;        // First beat already out
      else if (next_beat)
        beats_left <= beats_left - 1'b1;
    end
  end

  assign o_burst_busy = (beats_left != '0);

  // Master must not send more SEQ beats than the burst holds
  a_no_underflow: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (i_hready && next_beat) |-> (beats_left != '0));

endmodule

/* source/op_port_mux.sv */
// ------------------------------------------------------------
// Input port payload selector
// Picks one port's payload, zero when no port is selected
// ------------------------------------------------------------
`include "op_consts.svh"

module op_port_mux #(
  parameter type payload_t = ahb_pkg::data_t     // Routed payload
) (
  input  payload_t              i_payload [`OP_NUM_PORTS],  // One per port
  input  matrix_pkg::port_idx_t i_sel,     // Selected port
  input  logic                  i_none,    // Drive zeros instead
  output payload_t              o_payload
);

  always_comb
  begin
    if (i_none)
      o_payload = '0;                        // Quiet bus when unowned
    else
      o_payload = i_payload[i_sel];
  end

  // Selector comes from the arbiter or data-phase register
  always_comb
  begin
    if (!i_none)
      a_sel_range: assert (i_sel < `OP_NUM_PORTS);
  end

endmodule

/* source/op_data_phase.sv */
// ------------------------------------------------------------
// Data phase tracking
// Registers data-phase port and slave select, makes HREADYMUX
// ------------------------------------------------------------

module op_data_phase (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  matrix_pkg::port_idx_t i_grant,      // Address-phase owner
  input  logic                  i_hsel,       // Muxed HSEL
  input  logic                  i_hreadyout,  // From the slave
  output matrix_pkg::port_idx_t o_data_port,  // Owner of write data
  output logic                  o_hreadymux   // Slave-side HREADY
);

  logic slave_sel;   // Data phase targets this slave

  // ----------------------------------------------------------
  // Data-phase registers
  // ----------------------------------------------------------
  // Address phase moves into data phase on each accepted edge
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      o_data_port <= '0;
      slave_sel   <= 1'b0;
    end
    else if (o_hreadymux)
    begin
      o_data_port <= i_grant;                  // Write data follows
      slave_sel   <= i_hsel;
    end
  end

  // ----------------------------------------------------------
  // HREADYMUX generation
  // ----------------------------------------------------------
  // Slave drives ready only while its own data phase is live
  assign o_hreadymux = slave_sel ? i_hreadyout : 1'b1;

endmodule

/* source/op_output_stage.sv */
// ------------------------------------------------------------
// AHB bus-matrix output stage
// Arbitrates three input ports onto one shared slave and
// routes address, control and write data
// ------------------------------------------------------------
`include "op_consts.svh"

module op_output_stage (
  input  logic                                 HCLK,
  input  logic                                 HRESETn,
  input  logic [`OP_NUM_PORTS-1:0]             i_hsel,
  input  ahb_pkg::addr_t   [`OP_NUM_PORTS-1:0] i_haddr,
  input  ahb_pkg::htrans_t [`OP_NUM_PORTS-1:0] i_htrans,
  input  logic [`OP_NUM_PORTS-1:0]             i_hwrite,
  input  ahb_pkg::hsize_t  [`OP_NUM_PORTS-1:0] i_hsize,
  input  ahb_pkg::hburst_t [`OP_NUM_PORTS-1:0] i_hburst,
  input  ahb_pkg::hprot_t  [`OP_NUM_PORTS-1:0] i_hprot,
  input  ahb_pkg::hmaster_t [`OP_NUM_PORTS-1:0] i_hmaster,
  input  logic [`OP_NUM_PORTS-1:0]             i_hmastlock,
  input  ahb_pkg::data_t   [`OP_NUM_PORTS-1:0] i_hwdata,
  input  logic [`OP_NUM_PORTS-1:0]             i_held_tran,   // Pending for us
  input  logic                                 i_hreadyout,   // Slave ready
  output logic [`OP_NUM_PORTS-1:0]             o_active,      // Port owns slave
  output logic                                 o_hselm,
  output ahb_pkg::addr_t                       o_haddrm,
  output ahb_pkg::htrans_t                     o_htransm,
  output logic                                 o_hwritem,
  output ahb_pkg::hsize_t                      o_hsizem,
  output ahb_pkg::hburst_t                     o_hburstm,
  output ahb_pkg::hprot_t                      o_hprotm,
  output ahb_pkg::hmaster_t                    o_hmasterm,
  output logic                                 o_hmastlockm,
  output ahb_pkg::data_t                       o_hwdatam,
  output logic                                 o_hreadymuxm
);
  import ahb_pkg::*;
  import matrix_pkg::*;

  logic [`OP_NUM_PORTS-1:0] req;            // Held transfer and selected
  addr_ctrl_t port_ctrl [`OP_NUM_PORTS];    // Packed per-port address phase
  data_t      port_wdata [`OP_NUM_PORTS];
  addr_ctrl_t slave_ctrl;                   // Winner's address phase
  port_idx_t  grant;
  port_idx_t  data_port;
  logic       no_port;
  logic       burst_busy;
  logic       hreadymux;

  // ----------------------------------------------------------
  // Port packing
  // ----------------------------------------------------------
  assign req = i_held_tran & i_hsel;

  always_comb
  begin
    for (int p = 0; p < `OP_NUM_PORTS; p++)
    begin
      port_ctrl[p].hsel      = i_hsel[p];
      port_ctrl[p].haddr     = i_haddr[p];
      port_ctrl[p].htrans    = i_htrans[p];
      port_ctrl[p].hwrite    = i_hwrite[p];
      port_ctrl[p].hsize     = i_hsize[p];
      port_ctrl[p].hburst    = i_hburst[p];
      port_ctrl[p].hprot     = i_hprot[p];
      port_ctrl[p].hmaster   = i_hmaster[p];
      port_ctrl[p].hmastlock = i_hmastlock[p];
      port_wdata[p]          = i_hwdata[p];
    end
  end

  // ----------------------------------------------------------
  // Arbitration and routing
  // ----------------------------------------------------------
  op_arbiter u_arb (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_req        (req),
    .i_hready     (hreadymux),
    .i_hsel       (slave_ctrl.hsel),
    .i_htrans     (slave_ctrl.htrans),
    .i_hmastlock  (slave_ctrl.hmastlock),
    .i_burst_busy (burst_busy),
    .o_grant      (grant),
    .o_no_port    (no_port)
  );

  op_port_mux #(.payload_t(addr_ctrl_t)) u_addr_mux (
    .i_payload (port_ctrl),
    .i_sel     (grant),
    .i_none    (no_port),
    .o_payload (slave_ctrl)
  );

  op_beat_counter u_beats (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_hready     (hreadymux),
    .i_htrans     (slave_ctrl.htrans),
    .i_hburst     (slave_ctrl.hburst),
    .i_hsel       (slave_ctrl.hsel),
    .o_burst_busy (burst_busy)
  );

  op_data_phase u_data_phase (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_grant     (grant),
    .i_hsel      (slave_ctrl.hsel),
    .i_hreadyout (i_hreadyout),
    .o_data_port (data_port),
    .o_hreadymux (hreadymux)
  );

  // Write data lags one accepted edge behind the address
  op_port_mux #(.payload_t(data_t)) u_wdata_mux (
    .i_payload (port_wdata),
    .i_sel     (data_port),
    .i_none    (1'b0),
    .o_payload (o_hwdatam)
  );

  // Active decode
  always_comb
  begin
    for (int p = 0; p < `OP_NUM_PORTS; p++)
      o_active[p] = ~no_port & (grant == port_idx_t'(p));
  end

  // Slave-side unpacking
  assign o_hselm      = slave_ctrl.hsel;
  assign o_haddrm     = slave_ctrl.haddr;
  assign o_htransm    = slave_ctrl.htrans;
  assign o_hwritem    = slave_ctrl.hwrite;
  assign o_hsizem     = slave_ctrl.hsize;
  assign o_hburstm    = slave_ctrl.hburst;
  assign o_hprotm     = slave_ctrl.hprot;
  assign o_hmasterm   = slave_ctrl.hmaster;
  assign o_hmastlockm = slave_ctrl.hmastlock;
  assign o_hreadymuxm = hreadymux;

endmodule

/* tests/tb_output_stage.sv */
// ------------------------------------------------------------
// Output stage testbench
// Directed tests for grant, bursts, lock and slave stalls
// ------------------------------------------------------------
`include "op_consts.svh"

module tb_output_stage;
  import ahb_pkg::*;

  localparam int NP = `OP_NUM_PORTS;

  logic                HCLK;
  logic                HRESETn;
  logic [NP-1:0]       hsel;                 // Per-port bits
  logic [NP-1:0]       hwrite;
  logic [NP-1:0]       hmastlock;
  logic [NP-1:0]       held_tran;
  addr_t [NP-1:0]      haddr;
  htrans_t [NP-1:0]    htrans;
  hsize_t [NP-1:0]     hsize;
  hburst_t [NP-1:0]    hburst;
  hprot_t [NP-1:0]     hprot;
  hmaster_t [NP-1:0]   hmaster;
  data_t [NP-1:0]      hwdata;
  logic                hreadyout;
  logic [NP-1:0]       o_active;
  logic                o_hselm;
  logic                o_hwritem;
  logic                o_hmastlockm;
  logic                o_hreadymuxm;
  addr_t               o_haddrm;
  htrans_t             o_htransm;
  hsize_t              o_hsizem;
  hburst_t             o_hburstm;
  hprot_t              o_hprotm;
  hmaster_t            o_hmasterm;
  data_t               o_hwdatam;
  string               cur_test;
  int                  errors = 0;
  int                  test_errs = 0;
  int                  checks = 0;
  int                  tests = 0;

  op_output_stage dut_i (
    .HCLK(HCLK), .HRESETn(HRESETn),
    .i_hsel(hsel), .i_haddr(haddr), .i_htrans(htrans), .i_hwrite(hwrite),
    .i_hsize(hsize), .i_hburst(hburst), .i_hprot(hprot), .i_hmaster(hmaster),
    .i_hmastlock(hmastlock), .i_hwdata(hwdata), .i_held_tran(held_tran),
    .i_hreadyout(hreadyout), .o_active(o_active), .o_hselm(o_hselm),
    .o_haddrm(o_haddrm), .o_htransm(o_htransm), .o_hwritem(o_hwritem),
    .o_hsizem(o_hsizem), .o_hburstm(o_hburstm), .o_hprotm(o_hprotm),
    .o_hmasterm(o_hmasterm), .o_hmastlockm(o_hmastlockm),
    .o_hwdatam(o_hwdatam), .o_hreadymuxm(o_hreadymuxm)
  );

  initial
  begin
    HCLK = 1'b0;
    forever #10 HCLK = ~HCLK;                  // 20 unit period
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  task automatic tick();
    @(posedge HCLK);
    #2;                                        // Drive point after the edge
  endtask

  task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (exp !== act)
    begin
      $display("error %s %s: expected %0h actual %0h", cur_test, what, exp, act);
      errors++;
      test_errs++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests++;
    $display("%s: %s, %0d errors", cur_test, (test_errs == 0) ? "ok" : "FAILED", test_errs);
  endtask

  // Request the slave from one port with a write transfer
  task automatic drive_port(input int p, input htrans_t tr, input hburst_t bu,
                            input addr_t a, input logic lock);
    hsel[p]      = 1'b1;
    held_tran[p] = 1'b1;
    htrans[p]    = tr;
    hburst[p]    = bu;
    haddr[p]     = a;
    hwrite[p]    = 1'b1;
    hsize[p]     = 3'b010;                     // Word
    hprot[p]     = 4'b0011;
    hmaster[p]   = hmaster_t'(p + 1);
    hmastlock[p] = lock;
  endtask

  task automatic idle_port(input int p);
    hsel[p]      = 1'b0;
    held_tran[p] = 1'b0;
    htrans[p]    = IDLE;
    hmastlock[p] = 1'b0;
  endtask

  task automatic wait_active(input logic [NP-1:0] mask);
    int n;
    n = 0;
    while (o_active !== mask && n < 20)
    begin
      tick();
      n++;
    end
    if (o_active !== mask)
    begin
      $display("timeout in %s: o_active never reached %b", cur_test, mask);
      errors++;
      test_errs++;
    end
  endtask

  function automatic addr_t rand_addr();
    return addr_t'($urandom) & 32'hffff_fffc;  // Word aligned
  endfunction

  // ----------------------------------------------------------
  // Tests
  // ----------------------------------------------------------
  task automatic test_reset();
    start_test("reset_state");
    check("o_hselm", 0, o_hselm);
    check("o_active", 0, o_active);
    check("o_htransm", IDLE, o_htransm);
    check("o_hmastlockm", 0, o_hmastlockm);
    check("o_hreadymuxm", 1, o_hreadymuxm);
    end_test();
  endtask

  task automatic test_single_write();
    addr_t a;
    data_t d;
    start_test("single_write");
    a = rand_addr();
    d = data_t'($urandom);
    drive_port(1, NONSEQ, SINGLE, a, 1'b0);
    wait_active(3'b010);
    check("o_hselm", 1, o_hselm);
    check("o_haddrm", a, o_haddrm);
    check("o_htransm", NONSEQ, o_htransm);
    check("o_hwritem", 1, o_hwritem);
    check("o_hsizem", 3'b010, o_hsizem);
    check("o_hburstm", SINGLE, o_hburstm);
    check("o_hprotm", 4'b0011, o_hprotm);
    check("o_hmasterm", 2, o_hmasterm);
    tick();                                    // Address phase accepted
    idle_port(1);
    hwdata[1] = d;                             // Data phase of port 1
    #1;
    check("o_hwdatam", d, o_hwdatam);
    wait_active(3'b000);
    end_test();
  endtask

  task automatic test_priority();
    addr_t a0;
    start_test("fixed_priority");
    a0 = rand_addr();
    drive_port(0, NONSEQ, SINGLE, a0, 1'b0);
    drive_port(2, NONSEQ, SINGLE, rand_addr(), 1'b0);
    wait_active(3'b001);
    check("o_haddrm", a0, o_haddrm);
    check("o_hmasterm", 1, o_hmasterm);
    idle_port(0);
    idle_port(2);
    wait_active(3'b000);
    end_test();
  endtask

  task automatic test_burst_hold();
    addr_t a;
    addr_t a0;
    data_t d2;
    start_test("burst_hold");
    a  = rand_addr() & 32'hffff_ffc0;         // Keep four beats in one block
    a0 = rand_addr();
    d2 = data_t'($urandom);
    hwdata[2] = d2;
    hwdata[0] = ~d2;                           // Tell the two ports apart
    drive_port(2, NONSEQ, INCR4, a, 1'b0);
    wait_active(3'b100);
    tick();                                    // First beat accepted
    check("o_active beat 1", 3'b100, o_active);
    drive_port(0, NONSEQ, SINGLE, a0, 1'b0);
    for (int b = 1; b < 4; b++)
    begin
      htrans[2] = SEQ;
      haddr[2]  = a + addr_t'(4 * b);
      tick();
      check($sformatf("o_active beat %0d", b + 1), 3'b100, o_active);
    end
    idle_port(2);
    wait_active(3'b001);                       // Port 0 after the last beat
    check("o_haddrm", a0, o_haddrm);
    check("o_hwdatam last beat", d2, o_hwdatam);   // Data still from port 2
    idle_port(0);
    wait_active(3'b000);
    end_test();
  endtask

  task automatic test_locked();
    start_test("locked_sequence");
    drive_port(1, NONSEQ, SINGLE, rand_addr(), 1'b1);
    wait_active(3'b010);
    tick();                                    // First locked transfer
    drive_port(0, NONSEQ, SINGLE, rand_addr(), 1'b0);
    hsel[1]      = 1'b0;                       // Lock owner visits another slave
    held_tran[1] = 1'b0;
    tick();
    check("o_active hsel low", 3'b010, o_active);
    check("o_hmastlockm", 1, o_hmastlockm);
    hsel[1]      = 1'b1;
    held_tran[1] = 1'b1;
    tick();
    check("o_active resumed", 3'b010, o_active);
    idle_port(1);                              // Lock released
    #1;
    check("o_hmastlockm fell", 0, o_hmastlockm);
    check("o_active at unlock", 3'b010, o_active);
    wait_active(3'b001);
    idle_port(0);
    wait_active(3'b000);
    end_test();
  endtask

  task automatic test_stall();
    addr_t b;
    addr_t c;
    start_test("back_pressure");
    b = rand_addr();
    c = rand_addr();
    drive_port(2, NONSEQ, SINGLE, rand_addr(), 1'b0);
    wait_active(3'b100);
    tick();                                    // Port 2 now in data phase
    haddr[2] = b;                              // Next transfer held by master
    drive_port(0, NONSEQ, SINGLE, c, 1'b0);
    hreadyout = 1'b0;
    #1;
    check("o_hreadymuxm", 0, o_hreadymuxm);
    repeat (3)
    begin
      tick();
      check("o_hreadymuxm stalled", 0, o_hreadymuxm);
      check("o_active stalled", 3'b100, o_active);
      check("o_haddrm stalled", b, o_haddrm);
    end
    hreadyout = 1'b1;
    #1;
    check("o_hreadymuxm released", 1, o_hreadymuxm);
    tick();
    check("o_active after stall", 3'b001, o_active);
    check("o_haddrm after stall", c, o_haddrm);
    idle_port(0);
    idle_port(2);
    wait_active(3'b000);
    end_test();
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial
  begin
    void'($urandom(23067));
    HRESETn   = 1'b0;
    hreadyout = 1'b1;
    hwrite    = '0;
    haddr     = '0;
    hsize     = '0;
    hprot     = '0;
    hmaster   = '0;
    for (int p = 0; p < NP; p++)
    begin
      idle_port(p);
      hburst[p] = SINGLE;
      hwdata[p] = data_t'($urandom);
    end
    repeat (8) @(posedge HCLK);
    #2 HRESETn = 1'b1;
    test_reset();
    test_single_write();
    test_priority();
    test_burst_hold();
    test_locked();
    test_stall();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+source
source/ahb_pkg.sv
source/matrix_pkg.sv
source/op_arbiter.sv
source/op_beat_counter.sv
source/op_port_mux.sv
source/op_data_phase.sv
source/op_output_stage.sv
tests/tb_output_stage.sv

/* run.sh */
#!/bin/sh
# Build and run the output stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module tb_output_stage -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "All checks passed" sim.log; then
  exit 0
else
  exit 1
fi
